// File: src/iwmBusPkg.sv
package iwmBusPkg;

	// ====================
	// State pseudo-register
	// ====================

	// Bit address taken from addr[3:1]
	// New bit value comes on addr[0]
	typedef enum logic [2:0] {
		statePhase0  = 3'd0,
		statePhase1  = 3'd1,
		statePhase2  = 3'd2,
		statePhase3  = 3'd3,
		stateMotorOn = 3'd4,
		stateDriveSel = 3'd5,
		stateQ6      = 3'd6,
		stateQ7      = 3'd7
	} stateAddr;

	// Read register chosen by {q7, q6}
	localparam logic [1:0] readData      = 2'b00;
	localparam logic [1:0] readStatus    = 2'b01;
	localparam logic [1:0] readHandshake = 2'b10;
	localparam logic [1:0] readWriteMode = 2'b11;

	// ====================
	// Mode and data word
	// ====================

	// Mode register layout with latch in bit 0
	typedef struct packed {
		logic spare;
		logic mzReset;
		logic test;
		logic clk8MHz;
		logic fast;
		logic timerOff;
		logic async;
		logic latch;
	} modeFields;

	// One bus write word
	// Mode view with motor off, data byte with motor on
	typedef union packed {
		modeFields  mode;
		logic [7:0] data;
	} hostWrite;

	// Latch, async and timer off set after reset
	localparam modeFields modeReset = 8'h07;

	localparam logic [7:0] allOnes = 8'hFF;

endpackage

// File: src/iwmDiskPkg.sv
package iwmDiskPkg;

	// ====================
	// Write bit cell
	// ====================

	// Cell counter width in fclk cycles
	typedef logic [5:0] bitCellWidth;

	// Last timer value of a bit cell, indexed by {fast, clk8MHz}
	// Slow 7 MHz cell is 28 fclk, slow 8 MHz is 32
	// Fast mode halves both
	localparam bitCellWidth writeBitCellMax [0:3] = '{
		6'd27,
		6'd31,
		6'd13,
		6'd15
	};

	// ====================
	// Q7 filter
	// ====================

	// Rising side rejects short address glitches
	localparam int q7RiseWidth = 4;
	localparam logic [q7RiseWidth-1:0] q7RiseDefault = 4'd8;

	// Falling side rides through handshake polls
	// Q7 dips low for a few microseconds between data writes
	localparam int q7FallWidth = 7;
	localparam logic [q7FallWidth-1:0] q7FallDefault = 7'd100;

endpackage

// File: src/iwmRegisters.sv
`timescale 1ns/100ps

module iwmRegisters (
	input  logic       fclk,
	input  logic       nRES,
	input  logic [3:0] addr,
	input  logic       nDeviceSelect,
	input  logic [7:0] dataIn,
	input  logic       sense,
	input  logic       bufferEmpty,
	input  logic       underrunN,
	output logic [7:0] dataOut,
	output logic [3:0] phase,
	output logic       q7,
	output logic       modeFast,
	output logic       mode8MHz,
	output logic       dataWrite,
	output logic [7:0] writeByte,
	output logic       driveEnabled,
	output logic       nEnbl1,
	output logic       nEnbl2
);
	import iwmBusPkg::*;

	stateAddr   bitAddr;
	logic       selected;
	logic       nDevSelDly;
	logic       selectEdge;
	logic       motorOn;
	logic       driveSel;
	logic       q6;
	logic       regWrite;
	hostWrite   hostWord;
	modeFields  modeReg;
	logic       enableActive;
	logic [7:0] statusByte;
	logic [7:0] handshakeByte;

	assign bitAddr = stateAddr'(addr[3:1]);
	assign selected = ~nDeviceSelect;

	// First low cycle of device select after a high one
	assign selectEdge = nDevSelDly & ~nDeviceSelect;

	// ====================
	// State pseudo-register
	// ====================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			nDevSelDly <= 1'b1;
			phase <= 4'b0000;
			motorOn <= 1'b0;
			driveSel <= 1'b0;
			q6 <= 1'b0;
			q7 <= 1'b0;
		end else begin
			nDevSelDly <= nDeviceSelect;
			// Phases follow the bus level for the whole access
			if (selected) begin
				case (bitAddr)
					statePhase0: phase[0] <= addr[0];
					statePhase1: phase[1] <= addr[0];
					statePhase2: phase[2] <= addr[0];
					statePhase3: phase[3] <= addr[0];
					default: ;
				endcase
			end
			// Motor, drive, Q6 and Q7 only on the select edge
			// Odd/even addresses differ only in addr[0]
			if (selectEdge) begin
				case (bitAddr)
					stateMotorOn: motorOn <= addr[0];
					stateDriveSel: driveSel <= addr[0];
					stateQ6: q6 <= addr[0];
					stateQ7: q7 <= addr[0];
					default: ;
				endcase
			end
		end
	end

	// ====================
	// Mode and data write
	// ====================

	// Q7 Q6 A0 all set while selected
	assign regWrite = selected & q7 & q6 & addr[0];
	assign hostWord = hostWrite'(dataIn);

	// Motor on sends the byte to the write buffer
	// Strobe repeats for every selected cycle
	assign dataWrite = regWrite & motorOn;
	assign writeByte = hostWord.data;

	// Motor off loads the mode register
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			modeReg <= modeReset;
		end else if (regWrite && !motorOn) begin
			modeReg <= hostWord.mode;
		end
	end

	assign modeFast = modeReg.fast;
	assign mode8MHz = modeReg.clk8MHz;

	// Drive enables follow motor on directly
	assign nEnbl1 = ~(motorOn & ~driveSel);
	assign nEnbl2 = ~(motorOn & driveSel);
	assign enableActive = ~nEnbl1 | ~nEnbl2;
	assign driveEnabled = enableActive;

	// ====================
	// Read multiplexer
	// ====================
	assign statusByte = {sense, 1'b0, enableActive, modeReg[4:0]};
	assign handshakeByte = {bufferEmpty, underrunN, 6'b000000};

	// No read path, so data register reads as all ones
	always_comb begin
		case ({q7, q6})
			readStatus: dataOut = statusByte;
			readHandshake: dataOut = handshakeByte;
			readData, readWriteMode: dataOut = allOnes;
			default: dataOut = allOnes;
		endcase
	end

endmodule

// File: src/iwmWriteBuffer.sv
`timescale 1ns/100ps

module iwmWriteBuffer (
	input  logic       fclk,
	input  logic       nRES,
	input  logic       dataWrite,
	input  logic [7:0] writeByte,
	input  logic       take,
	input  logic       underrunN,
	output logic [7:0] heldByte,
	output logic       bufferEmpty
);

	logic accept;

	// Host writes refused during underrun
	// Keeps a trailing stray byte off the drive
	assign accept = dataWrite & underrunN;

	// ====================
	// Empty flag
	// ====================

	// Host write wins over a take in the same cycle
	// The serializer still gets the old byte that cycle
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			bufferEmpty <= 1'b1;
		end else if (accept) begin
			bufferEmpty <= 1'b0;
		end else if (take) begin
			bufferEmpty <= 1'b1;
		end
	end

	// ====================
	// Held byte
	// ====================

	// Repeated strobes rewrite the same value
	always_ff @(posedge fclk) begin
		if (accept) begin
			heldByte <= writeByte;
		end
	end

endmodule

// File: src/iwmWriteSerializer.sv
`timescale 1ns/100ps

module iwmWriteSerializer #(
	parameter logic [iwmDiskPkg::q7RiseWidth-1:0] Q7Rise = iwmDiskPkg::q7RiseDefault,
	parameter logic [iwmDiskPkg::q7FallWidth-1:0] Q7Fall = iwmDiskPkg::q7FallDefault
) (
	input  logic       fclk,
	input  logic       nRES,
	input  logic       q7,
	input  logic       modeFast,
	input  logic       mode8MHz,
	input  logic       driveEnabled,
	input  logic [7:0] heldByte,
	input  logic       bufferEmpty,
	output logic       take,
	output logic       underrunN,
	output logic       wrdata,
	output logic       nWrReq
);
	import iwmDiskPkg::*;

	logic [q7RiseWidth-1:0] riseCount;
	logic [q7FallWidth-1:0] fallCount;
	logic        q7Stable;
	logic        q7StableDly;
	logic        startWrite;
	logic        running;
	bitCellWidth cellMax;
	bitCellWidth bitTimer;
	logic [2:0]  bitsLeft;
	logic [7:0]  shifter;
	logic        cellWrap;
	logic        byteBoundary;

	// ====================
	// Q7 stability filter
	// ====================

	// High for Q7Rise+1 cycles to rise
	// Low for Q7Fall+1 cycles to fall
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			riseCount <= '0;
			fallCount <= '0;
			q7Stable <= 1'b0;
		end else if (q7) begin
			fallCount <= '0;
			if (!q7Stable) begin
				if (riseCount < Q7Rise) begin
					riseCount <= riseCount + 1'b1;
				end else begin
					q7Stable <= 1'b1;
				end
			end
		end else begin
			riseCount <= '0;
			if (q7Stable) begin
				if (fallCount < Q7Fall) begin
					fallCount <= fallCount + 1'b1;
				end else begin
					q7Stable <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			q7StableDly <= 1'b0;
		end else begin
			q7StableDly <= q7Stable;
		end
	end

	// Init cycle right after the filter rises
	assign startWrite = q7Stable & ~q7StableDly;
	assign running = q7Stable & q7StableDly;

	// ====================
	// Bit timer
	// ====================
	assign cellMax = writeBitCellMax[{modeFast, mode8MHz}];
	assign cellWrap = running & (bitTimer == cellMax);

	// Eighth wrap since the last load
	assign byteBoundary = cellWrap & (bitsLeft == 3'd0);
	assign take = byteBoundary & ~bufferEmpty;

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			bitTimer <= '0;
			bitsLeft <= 3'd7;
		end else if (startWrite) begin
			bitTimer <= '0;
			bitsLeft <= 3'd7;
		end else if (cellWrap) begin
			bitTimer <= '0;
			// Wraps from 0 back to 7 at the byte boundary
			bitsLeft <= bitsLeft - 3'd1;
		end else if (running) begin
			bitTimer <= bitTimer + 1'b1;
		end
	end

	// Sync preamble of all ones, then host bytes MSB first
	always_ff @(posedge fclk) begin
		if (startWrite) begin
			shifter <= 8'hFF;
		end else if (take) begin
			shifter <= heldByte;
		end else if (cellWrap) begin
			shifter <= {shifter[6:0], 1'b0};
		end
	end

	// ====================
	// Output and underrun
	// ====================

	// One bit is a transition early in the cell
	// Underrun parks wrdata low on the same edge
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			underrunN <= 1'b1;
			wrdata <= 1'b0;
		end else if (!q7Stable) begin
			underrunN <= 1'b1;
			wrdata <= 1'b0;
		end else if (byteBoundary && bufferEmpty) begin
			underrunN <= 1'b0;
			wrdata <= 1'b0;
		end else if (!underrunN) begin
			wrdata <= 1'b0;
		end else if (running && bitTimer == 6'd1 && shifter[7]) begin
			wrdata <= ~wrdata;
		end
	end

	// Request only with a confirmed write, live data and a selected drive
	assign nWrReq = ~(q7Stable & underrunN & driveEnabled);

endmodule

// File: src/iwm.sv
`timescale 1ns/100ps

module iwm #(
	parameter logic [iwmDiskPkg::q7RiseWidth-1:0] Q7Rise = iwmDiskPkg::q7RiseDefault,
	parameter logic [iwmDiskPkg::q7FallWidth-1:0] Q7Fall = iwmDiskPkg::q7FallDefault
) (
	input  logic       fclk,
	input  logic       nRES,
	// Host bus
	input  logic [3:0] addr,
	input  logic       nDeviceSelect,
	input  logic [7:0] dataIn,
	output logic [7:0] dataOut,
	// Drive side
	input  logic       sense,
	output logic       wrdata,
	output logic [3:0] phase,
	output logic       nWrReq,
	output logic       nEnbl1,
	output logic       nEnbl2
);

	logic       q7;
	logic       modeFast;
	logic       mode8MHz;
	logic       dataWrite;
	logic [7:0] writeByte;
	logic       driveEnabled;
	logic       bufferEmpty;
	logic       underrunN;
	logic [7:0] heldByte;
	logic       take;

	// ====================
	// Host registers
	// ====================
	iwmRegisters registers (
		.fclk(fclk),
		.nRES(nRES),
		.addr(addr),
		.nDeviceSelect(nDeviceSelect),
		.dataIn(dataIn),
		.sense(sense),
		.bufferEmpty(bufferEmpty),
		.underrunN(underrunN),
		.dataOut(dataOut),
		.phase(phase),
		.q7(q7),
		.modeFast(modeFast),
		.mode8MHz(mode8MHz),
		.dataWrite(dataWrite),
		.writeByte(writeByte),
		.driveEnabled(driveEnabled),
		.nEnbl1(nEnbl1),
		.nEnbl2(nEnbl2)
	);

	// One byte between host and serializer
	iwmWriteBuffer writeBuffer (
		.fclk(fclk),
		.nRES(nRES),
		.dataWrite(dataWrite),
		.writeByte(writeByte),
		.take(take),
		.underrunN(underrunN),
		.heldByte(heldByte),
		.bufferEmpty(bufferEmpty)
	);

	// ====================
	// Write serializer
	// ====================
	iwmWriteSerializer #(
		.Q7Rise(Q7Rise),
		.Q7Fall(Q7Fall)
	) writeSerializer (
		.fclk(fclk),
		.nRES(nRES),
		.q7(q7),
		.modeFast(modeFast),
		.mode8MHz(mode8MHz),
		.driveEnabled(driveEnabled),
		.heldByte(heldByte),
		.bufferEmpty(bufferEmpty),
		.take(take),
		.underrunN(underrunN),
		.wrdata(wrdata),
		.nWrReq(nWrReq)
	);

endmodule

// File: verif/iwmSerial_chk.sv
`timescale 1ns/100ps

module iwmSerialChk (
	input logic fclk,
	input logic nRES,
	input logic q7,
	input logic q7Stable,
	input logic underrunN,
	input logic wrdata,
	input logic nWrReq,
	input logic take,
	input logic bufferEmpty
);

	// ====================
	// Write line
	// ====================

	// Parked during underrun
	wrdataParked: assert property (@(posedge fclk) disable iff (!nRES)
		!underrunN |=> $stable(wrdata))
		else $error("wrdata changed while underrun was active");

	// Filter never confirms Q7 from a low cycle
	requestNeedsQ7: assert property (@(posedge fclk) disable iff (!nRES)
		!q7 && !q7Stable |=> nWrReq)
		else $error("nWrReq went active right after q7 was low with the filter off");

	// ====================
	// Buffer handoff
	// ====================

	// A byte leaves the buffer only through a take
	takeEmptiesBuffer: assert property (@(posedge fclk) disable iff (!nRES)
		$rose(bufferEmpty) |-> $past(take))
		else $error("bufferEmpty rose without a take from the serializer");

endmodule

bind iwmWriteSerializer iwmSerialChk serialChk (
	.fclk(fclk),
	.nRES(nRES),
	.q7(q7),
	.q7Stable(q7Stable),
	.underrunN(underrunN),
	.wrdata(wrdata),
	.nWrReq(nWrReq),
	.take(take),
	.bufferEmpty(bufferEmpty)
);

// File: verif/iwmTb.sv
`timescale 1ns/100ps

module iwmTb;
	import iwmBusPkg::*;
	import iwmDiskPkg::*;

	logic       fclk;
	logic       nRES;
	logic [3:0] addr;
	logic       nDeviceSelect;
	logic [7:0] dataIn;
	logic [7:0] dataOut;
	logic       sense;
	logic       wrdata;
	logic [3:0] phase;
	logic       nWrReq;
	logic       nEnbl1;
	logic       nEnbl2;

	int seed;
	int errorCount;
	int testCount;
	int failedTests;
	string testName;

	iwm DUT (
		.fclk(fclk),
		.nRES(nRES),
		.addr(addr),
		.nDeviceSelect(nDeviceSelect),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.sense(sense),
		.wrdata(wrdata),
		.phase(phase),
		.nWrReq(nWrReq),
		.nEnbl1(nEnbl1),
		.nEnbl2(nEnbl2)
	);

	always #5 fclk = ~fclk;

	// ====================
	// Helpers
	// ====================
	task automatic reportMismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		$display("mismatch %s %s: expected %h, actual %h", testName, name, expected, actual);
		errorCount++;
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("test %s: ok", name);
		end else begin
			failedTests++;
			$display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	function automatic int countOnes(input logic [7:0] value);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++) begin
			if (value[i]) ones++;
		end
		return ones;
	endfunction

	// One access, two cycles selected then one idle
	// Called and returns 1 ns after a rising edge
	task automatic busAccess(input logic [3:0] address, input logic [7:0] data);
		addr = address;
		dataIn = data;
		nDeviceSelect = 1'b0;
		repeat (2) @(posedge fclk);
		#1;
		nDeviceSelect = 1'b1;
		@(posedge fclk);
		#1;
	endtask

	// Q7/Q6 = 00, 01 or 10 only
	// The bit going low is cleared first, so no odd access sees both set
	task automatic readReg(input logic [1:0] q7q6, output logic [7:0] result);
		if (!q7q6[1]) begin
			busAccess({stateQ7, q7q6[1]}, 8'h00);
			busAccess({stateQ6, q7q6[0]}, 8'h00);
		end else begin
			busAccess({stateQ6, q7q6[0]}, 8'h00);
			busAccess({stateQ7, q7q6[1]}, 8'h00);
		end
		result = dataOut;
	endtask

	// Motor must be off, Q7 left low afterwards
	task automatic writeMode(input logic [7:0] value);
		busAccess({stateQ7, 1'b0}, 8'h00);
		busAccess({stateQ6, 1'b1}, 8'h00);
		busAccess({stateQ7, 1'b1}, value);
		busAccess({stateQ7, 1'b0}, 8'h00);
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic resetValues();
		int errorsBefore;
		logic [7:0] readValue;
		errorsBefore = errorCount;
		testName = "resetValues";
		// Enables and request inactive, write line low
		if ({nEnbl1, nEnbl2, nWrReq, wrdata} !== 4'b1110) begin
			reportMismatch("reset outputs", 8'h0E, {4'h0, nEnbl1, nEnbl2, nWrReq, wrdata});
		end
		// Handshake first, status read drops Q7 again
		readReg(2'b10, readValue);
		if (readValue !== 8'hC0) reportMismatch("reset handshake", 8'hC0, readValue);
		readReg(2'b01, readValue);
		if (readValue !== {3'b000, modeReset[4:0]}) begin
			reportMismatch("reset status", {3'b000, modeReset[4:0]}, readValue);
		end
		finishTest("resetValues", errorsBefore);
	endtask

	task automatic modeStatus();
		int errorsBefore;
		logic [7:0] modeByte;
		logic [7:0] readValue;
		errorsBefore = errorCount;
		testName = "modeStatus";
		modeByte = 8'($random(seed));
		writeMode(modeByte);
		// Sense lands in bit 7, enables off
		for (int s = 0; s < 2; s++) begin
			sense = (s == 1);
			readReg(2'b01, readValue);
			if (readValue !== {sense, 2'b00, modeByte[4:0]}) begin
				reportMismatch("mode status", {sense, 2'b00, modeByte[4:0]}, readValue);
			end
		end
		sense = 1'b0;
		finishTest("modeStatus", errorsBefore);
	endtask

	task automatic phasesEnables();
		int errorsBefore;
		logic [3:0] expPhase;
		logic [7:0] readValue;
		errorsBefore = errorCount;
		testName = "phasesEnables";
		// Raise then drop each phase on its own
		for (int i = 0; i < 4; i++) begin
			expPhase = 4'b0001 << i;
			busAccess(4'(2 * i + 1), 8'h00);
			if (phase !== expPhase) begin
				reportMismatch("phase set", {4'h0, expPhase}, {4'h0, phase});
			end
			busAccess(4'(2 * i), 8'h00);
			if (phase !== 4'b0000) reportMismatch("phase clear", 8'h00, {4'h0, phase});
		end
		// Drive 1 first, then drive 2
		busAccess({stateDriveSel, 1'b0}, 8'h00);
		busAccess({stateMotorOn, 1'b1}, 8'h00);
		if ({nEnbl2, nEnbl1} !== 2'b10) begin
			reportMismatch("enable 1", 8'h02, {6'h00, nEnbl2, nEnbl1});
		end
		readReg(2'b01, readValue);
		if (readValue[5] !== 1'b1) begin
			reportMismatch("enable 1 status", 8'h01, {7'h00, readValue[5]});
		end
		busAccess({stateDriveSel, 1'b1}, 8'h00);
		if ({nEnbl2, nEnbl1} !== 2'b01) begin
			reportMismatch("enable 2", 8'h01, {6'h00, nEnbl2, nEnbl1});
		end
		readReg(2'b01, readValue);
		if (readValue[5] !== 1'b1) begin
			reportMismatch("enable 2 status", 8'h01, {7'h00, readValue[5]});
		end
		finishTest("phasesEnables", errorsBefore);
	endtask

	task automatic q7Glitch();
		int errorsBefore;
		int cycles;
		logic bad;
		errorsBefore = errorCount;
		testName = "q7Glitch";
		bad = 1'b0;
		// Q6 low so the odd Q7 access is not a data write
		busAccess({stateQ6, 1'b0}, 8'h00);
		busAccess({stateQ7, 1'b1}, 8'h00);
		if ({nWrReq, wrdata} !== 2'b10) begin
			reportMismatch("q7 pulse", 8'h02, {6'h00, nWrReq, wrdata});
		end
		busAccess({stateQ7, 1'b0}, 8'h00);
		// Watch past the rise window
		cycles = 0;
		while (!bad && cycles < int'(q7RiseDefault) + 8) begin
			if ({nWrReq, wrdata} !== 2'b10) begin
				reportMismatch("q7 after pulse", 8'h02, {6'h00, nWrReq, wrdata});
				bad = 1'b1;
			end
			@(posedge fclk);
			#1;
			cycles++;
		end
		finishTest("q7Glitch", errorsBefore);
	endtask

	task automatic byteSerialize();
		int errorsBefore;
		int cycles;
		int transitions;
		logic started;
		logic done;
		logic lastWrdata;
		logic [7:0] dataByte;
		logic [7:0] readValue;
		errorsBefore = errorCount;
		testName = "byteSerialize";
		// Slow 7 MHz cell needs motor off for the mode write
		busAccess({stateMotorOn, 1'b0}, 8'h00);
		writeMode(8'h07);
		busAccess({stateMotorOn, 1'b1}, 8'h00);
		busAccess({stateQ6, 1'b1}, 8'h00);
		dataByte = 8'($random(seed));
		busAccess({stateQ7, 1'b1}, dataByte);
		// Count toggles while the request is active
		started = 1'b0;
		done = 1'b0;
		transitions = 0;
		cycles = 0;
		lastWrdata = wrdata;
		while (!done && cycles < 2000) begin
			@(posedge fclk);
			#1;
			cycles++;
			if (!nWrReq) begin
				started = 1'b1;
			end else if (started) begin
				done = 1'b1;
			end
			if (!done && wrdata !== lastWrdata) transitions++;
			lastWrdata = wrdata;
		end
		if (!done) begin
			$display("byteSerialize: timeout, the write request never ended in underrun");
			errorCount++;
		end
		// Preamble of eight ones, then one transition per one bit
		if (transitions != 8 + countOnes(dataByte)) begin
			reportMismatch("wrdata transitions", 8'(8 + countOnes(dataByte)), 8'(transitions));
		end
		readReg(2'b10, readValue);
		if (readValue !== 8'h80) reportMismatch("underrun handshake", 8'h80, readValue);
		finishTest("byteSerialize", errorsBefore);
	endtask

	task automatic writeAfterUnderrun();
		int errorsBefore;
		logic [7:0] dataByte;
		logic [7:0] readValue;
		errorsBefore = errorCount;
		testName = "writeAfterUnderrun";
		dataByte = 8'($random(seed));
		// Q7 still set, so both accesses are data writes
		busAccess({stateQ6, 1'b1}, dataByte);
		busAccess({stateQ7, 1'b1}, dataByte);
		readReg(2'b10, readValue);
		if (readValue !== 8'h80) reportMismatch("refused write", 8'h80, readValue);
		if (wrdata !== 1'b0) reportMismatch("wrdata parked", 8'h00, {7'h00, wrdata});
		finishTest("writeAfterUnderrun", errorsBefore);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		fclk = 1'b0;
		nRES = 1'b0;
		addr = 4'h0;
		nDeviceSelect = 1'b1;
		dataIn = 8'h00;
		sense = 1'b0;
		seed = 32'hf6237d45;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		testName = "";
		repeat (4) @(posedge fclk);
		#1;
		nRES = 1'b1;
		@(posedge fclk);
		#1;
		resetValues();
		modeStatus();
		phasesEnables();
		q7Glitch();
		byteSerialize();
		writeAfterUnderrun();
		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: build.f
src/iwmBusPkg.sv
src/iwmDiskPkg.sv
src/iwmRegisters.sv
src/iwmWriteBuffer.sv
src/iwmWriteSerializer.sv
src/iwm.sv
verif/iwmSerial_chk.sv
verif/iwmTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module iwmTb -f build.f

output=$(./obj_dir/ViwmTb)
echo "$output"

if echo "$output" | grep -q "PASS: all tests"; then
	exit 0
fi
exit 1
